// File: hdl/eval_consts.svh
`ifndef EVAL_CONSTS_SVH
`define EVAL_CONSTS_SVH

`define EVAL_WIDTH     16
`define PHASE_MAX      62
`define BLEND_MULT     16912 // floor(2^20 / 62)
`define BLEND_SHIFT    20
`define BLEND_LATENCY  4

// Piece values, middlegame then endgame
`define PAWN_MG        82
`define PAWN_EG        94
`define KNIGHT_MG      337
`define KNIGHT_EG      281
`define BISHOP_MG      365
`define BISHOP_EG      297
`define ROOK_MG        477
`define ROOK_EG        512
`define QUEEN_MG       1025
`define QUEEN_EG       936
`define KING_MG        0
`define KING_EG        0

`define DOUBLED_MG     10 // Per extra pawn on a file
`define DOUBLED_EG     20
`define ISOLATED_MG    5  // Per pawn without friendly neighbour files
`define ISOLATED_EG    15

`endif

// File: hdl/board_pkg.sv
package board_pkg;

   // Low three bits of a square code
   typedef enum logic [2:0]
   {
      EMPTY  = 3'd0,
      PAWN   = 3'd1,
      KNIGHT = 3'd2,
      BISHOP = 3'd3,
      ROOK   = 3'd4,
      QUEEN  = 3'd5,
      KING   = 3'd6
   } piece_kind_e;

   // Bit 3 set means a black piece
   typedef struct packed
   {
      logic        black;
      piece_kind_e kind;
   } piece_t;

   // Square index is rank * 8 + file, a1 at index 0
   typedef piece_t [63:0] board_t;

endpackage

// File: hdl/eval_pkg.sv
`include "eval_consts.svh"

package eval_pkg;

   // Middlegame and endgame halves of one score
   typedef struct packed
   {
      logic signed [`EVAL_WIDTH-1:0] mg;
      logic signed [`EVAL_WIDTH-1:0] eg;
   } score_t;

   // One done bit per sub-evaluator
   typedef struct packed
   {
      logic material;
      logic pawns_white;
      logic pawns_black;
   } eval_status_t;

endpackage

// File: hdl/eval_material.sv
`timescale 1ns/1ps
`include "eval_consts.svh"

module eval_material (
   input  logic                clk,
   input  logic                reset,
   input  logic                start,
   input  logic                clear_eval,
   input  board_pkg::board_t   board,
   output eval_pkg::score_t    score,
   output logic                valid,
   output logic signed [31:0]  material,
   output logic                insufficient_material
);
   import board_pkg::*;
   import eval_pkg::*;

   logic [6:0]         cnt_w_c [8];
   logic [6:0]         cnt_b_c [8];
   logic [6:0]         cnt_w [8];      // Piece counts per type, white
   logic [6:0]         cnt_b [8];      // Same for black
   logic signed [31:0] mg_acc;
   logic signed [31:0] eg_acc;
   logic               bare_c;
   logic               start_r;

   function automatic score_t piece_value(input piece_kind_e kind);
      score_t v;
      case (kind)
         PAWN:    begin v.mg = `EVAL_WIDTH'(`PAWN_MG);   v.eg = `EVAL_WIDTH'(`PAWN_EG);   end
         KNIGHT:  begin v.mg = `EVAL_WIDTH'(`KNIGHT_MG); v.eg = `EVAL_WIDTH'(`KNIGHT_EG); end
         BISHOP:  begin v.mg = `EVAL_WIDTH'(`BISHOP_MG); v.eg = `EVAL_WIDTH'(`BISHOP_EG); end
         ROOK:    begin v.mg = `EVAL_WIDTH'(`ROOK_MG);   v.eg = `EVAL_WIDTH'(`ROOK_EG);   end
         QUEEN:   begin v.mg = `EVAL_WIDTH'(`QUEEN_MG);  v.eg = `EVAL_WIDTH'(`QUEEN_EG);  end
         KING:    begin v.mg = `EVAL_WIDTH'(`KING_MG);   v.eg = `EVAL_WIDTH'(`KING_EG);   end
         default: v = '0;
      endcase
      return v;
   endfunction

   always_comb
   begin
      for (int t = 0; t < 8; t++)
      begin
         cnt_w_c[t] = '0;
         cnt_b_c[t] = '0;
      end
      for (int sq = 0; sq < 64; sq++)
      begin
         if (board[sq].black)
            cnt_b_c[board[sq].kind] = cnt_b_c[board[sq].kind] + 7'd1;
         else
            cnt_w_c[board[sq].kind] = cnt_w_c[board[sq].kind] + 7'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      cnt_w <= cnt_w_c;                   // Stage 1
      cnt_b <= cnt_b_c;
   end

   always_comb
   begin
      score_t v;
      mg_acc = '0;
      eg_acc = '0;
      for (int t = 1; t < 7; t++)
      begin
         v = piece_value(piece_kind_e'(t));
         mg_acc = mg_acc + (32'(cnt_w[t]) - 32'(cnt_b[t])) * 32'(v.mg);
         eg_acc = eg_acc + (32'(cnt_w[t]) - 32'(cnt_b[t])) * 32'(v.eg);
      end
      // Kings plus at most one minor piece per side
      bare_c = (cnt_w[PAWN] == 0) && (cnt_b[PAWN] == 0) &&
               (cnt_w[ROOK] == 0) && (cnt_b[ROOK] == 0) &&
               (cnt_w[QUEEN] == 0) && (cnt_b[QUEEN] == 0) &&
               ({1'b0, cnt_w[KNIGHT]} + {1'b0, cnt_w[BISHOP]} <= 8'd1) &&
               ({1'b0, cnt_b[KNIGHT]} + {1'b0, cnt_b[BISHOP]} <= 8'd1);
   end

   always_ff @(posedge clk)
   begin
      score.mg              <= mg_acc[`EVAL_WIDTH-1:0]; // Stage 2
      score.eg              <= eg_acc[`EVAL_WIDTH-1:0];
      material              <= mg_acc;
      insufficient_material <= bare_c;
   end

   always_ff @(posedge clk)
   begin
      if (reset || clear_eval)
      begin
         start_r <= 1'b0;
         valid   <= 1'b0;
      end
      else
      begin
         start_r <= start;
         valid   <= start_r;                 // Follows the two data stages
      end
   end

   a_valid_after_start: assert property (@(posedge clk) disable iff (reset)
      $rose(valid) |-> $past(start, 1) && $past(start, 2));

endmodule

// File: hdl/eval_pawns.sv
`timescale 1ns/1ps
`include "eval_consts.svh"

module eval_pawns #(
   parameter int white_pawns = 1
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              start,
   input  logic              clear_eval,
   input  board_pkg::board_t board,
   output eval_pkg::score_t  score,
   output logic              valid
);
   import board_pkg::*;

   localparam bit IS_WHITE = (white_pawns != 0);

   logic [3:0]         file_cnt_c [8];
   logic [3:0]         file_cnt [8];   // Own pawns per file
   logic [9:0]         has_pawn;       // Padded with empty files at both edges
   logic [6:0]         doubled;
   logic [6:0]         isolated;
   logic signed [31:0] pen_mg;
   logic signed [31:0] pen_eg;
   logic               start_r;

   always_comb
   begin
      for (int f = 0; f < 8; f++)
      begin
         file_cnt_c[f] = '0;
         for (int r = 0; r < 8; r++)
         begin
            if (board[r * 8 + f].kind == PAWN && board[r * 8 + f].black == !IS_WHITE)
               file_cnt_c[f] = file_cnt_c[f] + 4'd1;
         end
      end
   end

   always_ff @(posedge clk)
      file_cnt <= file_cnt_c;               // Stage 1

   always_comb
   begin
      has_pawn = '0;
      for (int f = 0; f < 8; f++)
         has_pawn[f + 1] = (file_cnt[f] != 0);
      doubled  = '0;
      isolated = '0;
      for (int f = 0; f < 8; f++)
      begin
         if (file_cnt[f] > 4'd1)
            doubled = doubled + 7'(file_cnt[f] - 4'd1);
         if (!has_pawn[f] && !has_pawn[f + 2])
            isolated = isolated + 7'(file_cnt[f]);
      end
      pen_mg = 32'(doubled) * `DOUBLED_MG + 32'(isolated) * `ISOLATED_MG;
      pen_eg = 32'(doubled) * `DOUBLED_EG + 32'(isolated) * `ISOLATED_EG;
   end

   // White's view: own weaknesses cost white, black's help white
   always_ff @(posedge clk)
   begin
      score.mg <= IS_WHITE ? -pen_mg[`EVAL_WIDTH-1:0] : pen_mg[`EVAL_WIDTH-1:0];
      score.eg <= IS_WHITE ? -pen_eg[`EVAL_WIDTH-1:0] : pen_eg[`EVAL_WIDTH-1:0];
   end

   always_ff @(posedge clk)
   begin
      if (reset || clear_eval)
      begin
         start_r <= 1'b0;
         valid   <= 1'b0;
      end
      else
      begin
         start_r <= start;
         valid   <= start_r;
      end
   end

   a_valid_clears: assert property (@(posedge clk) disable iff (reset)
      clear_eval |=> !valid);

endmodule

// File: hdl/square_popcount.sv
`timescale 1ns/1ps

module square_popcount (
   input  logic        clk,
   input  logic        reset,
   input  logic [63:0] occupied,
   output logic [6:0]  population
);

   logic [3:0] byte_cnt [8];               // Stage 1 partial counts
   logic [6:0] total_c;

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < 8; i++)
      begin
         if (reset)
            byte_cnt[i] <= '0;
         else
            byte_cnt[i] <= 4'($countones(occupied[i * 8 +: 8]));
      end
   end

   always_comb
   begin
      total_c = '0;
      for (int i = 0; i < 8; i++)
         total_c = total_c + 7'(byte_cnt[i]);
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         population <= '0;
      else
         population <= total_c;              // Stage 2
   end

endmodule

// File: hdl/evaluate.sv
`timescale 1ns/1ps
`include "eval_consts.svh"

module evaluate (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          board_valid,
   input  board_pkg::board_t             board_in,
   input  logic                          clear_eval,
   output logic signed [`EVAL_WIDTH-1:0] eval,
   output logic                          eval_valid,
   output logic signed [31:0]            material,
   output logic                          insufficient_material
);
   import board_pkg::*;
   import eval_pkg::*;

   localparam int SUM_W   = `EVAL_WIDTH + 2; // Three scores summed
   localparam int PROD_W  = SUM_W + 8;
   localparam int MIX_W   = PROD_W + 1;
   localparam int SCALE_W = MIX_W + 17;
   localparam logic signed [16:0]        BLEND_K   = 17'(`BLEND_MULT);
   localparam logic signed [SCALE_W-1:0] ROUND_ADD = (SCALE_W'(1) << `BLEND_SHIFT) - 1;

   typedef enum logic [1:0] {IDLE, WAIT_EVAL, WAIT_LATENCY, DONE} state_e;

   state_e              state;
   logic                board_valid_r;
   logic                start;
   logic [2:0]          latency;
   board_t              board;
   logic [63:0]         occupied;
   logic [6:0]          population;
   score_t              mat_score, pw_score, pb_score;
   eval_status_t        status;
   logic [5:0]          phase, phase_eg;
   logic signed [SUM_W-1:0]   sum_mg, sum_eg;
   logic signed [PROD_W-1:0]  prod_mg, prod_eg;
   logic signed [MIX_W-1:0]   mixed;
   logic signed [SCALE_W-1:0] scaled, biased;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= IDLE;
         board_valid_r <= 1'b0;
         start         <= 1'b0;
         eval_valid    <= 1'b0;
         latency       <= '0;
      end
      else
      begin
         board_valid_r <= board_valid;
         case (state)
            IDLE:
               if (board_valid && !board_valid_r)
               begin
                  state <= WAIT_EVAL;
                  start <= 1'b1;
               end
            WAIT_EVAL:
               if (status == eval_status_t'('1))
               begin
                  state   <= WAIT_LATENCY;
                  latency <= '0;
               end
            WAIT_LATENCY:
            begin
               latency <= latency + 3'd1;
               if (latency == 3'(`BLEND_LATENCY - 1))
               begin
                  state      <= DONE;
                  eval_valid <= 1'b1;
               end
            end
            default: ;                      // DONE holds until cleared
         endcase
         if (clear_eval && state != IDLE)
         begin
            state      <= IDLE;
            start      <= 1'b0;
            eval_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
      if (state == IDLE)
         board <= board_in;                 // Tracks the host until capture

   always_comb
      for (int sq = 0; sq < 64; sq++)
         occupied[sq] = (board[sq].kind != EMPTY);

   eval_material u_material (
      .clk(clk), .reset(reset), .start(start), .clear_eval(clear_eval), .board(board),
      .score(mat_score), .valid(status.material), .material(material),
      .insufficient_material(insufficient_material));

   eval_pawns #(.white_pawns(1)) u_pawns_white (
      .clk(clk), .reset(reset), .start(start), .clear_eval(clear_eval), .board(board),
      .score(pw_score), .valid(status.pawns_white));

   eval_pawns #(.white_pawns(0)) u_pawns_black (
      .clk(clk), .reset(reset), .start(start), .clear_eval(clear_eval), .board(board),
      .score(pb_score), .valid(status.pawns_black));

   square_popcount u_popcount (
      .clk(clk), .reset(reset), .occupied(occupied), .population(population));

   assign biased = scaled + (scaled < 0 ? ROUND_ADD : '0); // Round toward zero

   always_ff @(posedge clk)
   begin
      phase    <= (population > 7'(`PHASE_MAX)) ? 6'(`PHASE_MAX) : population[5:0];
      phase_eg <= (population > 7'(`PHASE_MAX)) ? 6'd0 : 6'(`PHASE_MAX) - population[5:0];
      sum_mg   <= SUM_W'(mat_score.mg) + SUM_W'(pw_score.mg) + SUM_W'(pb_score.mg);
      sum_eg   <= SUM_W'(mat_score.eg) + SUM_W'(pw_score.eg) + SUM_W'(pb_score.eg);
      prod_mg  <= sum_mg * $signed({2'b00, phase});    // Blend 1
      prod_eg  <= sum_eg * $signed({2'b00, phase_eg});
      mixed    <= MIX_W'(prod_mg) + MIX_W'(prod_eg);   // Blend 2
      scaled   <= mixed * BLEND_K;                     // Blend 3
      eval     <= biased[`BLEND_SHIFT +: `EVAL_WIDTH]; // Blend 4
   end

   a_valid_in_done: assert property (@(posedge clk) disable iff (reset)
      eval_valid |-> state == DONE);

endmodule

// File: dv/eval_checker.sv
`timescale 1ns/1ps
`include "eval_consts.svh"

module eval_checker (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          clear_eval,
   input  logic                          eval_valid,
   input  logic signed [`EVAL_WIDTH-1:0] eval,
   input  logic signed [31:0]            material,
   input  logic                          insufficient_material,
   input  int                            case_id,
   input  logic signed [`EVAL_WIDTH-1:0] exp_eval,
   input  logic signed [31:0]            exp_material,
   input  logic                          exp_insufficient,
   output int                            errors,
   output int                            results
);

   int                            id_seen;
   int                            last_id;
   logic                          clear_seen;
   logic                          valid_prev;
   logic signed [`EVAL_WIDTH-1:0] eval_held;
   logic signed [31:0]            material_held;
   logic                          insuf_held;

   initial
   begin
      errors     = 0;
      results    = 0;
      id_seen    = -1;
      last_id    = -1;
      clear_seen = 1'b0;
      valid_prev = 1'b0;
   end

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
      if (got !== expected)
      begin
         errors++;
         $display("[FAIL] case %0d %s: got 0x%h, expected 0x%h", id_seen, name, got, expected);
      end
   endtask

   // Host inputs as the DUT saw them
   always @(posedge clk)
   begin
      clear_seen <= clear_eval;
      id_seen    <= case_id;
   end

   // DUT outputs are settled on the falling edge
   always @(negedge clk)
   begin
      if (reset)
         valid_prev = 1'b0;
      else
      begin
         if (eval_valid && !valid_prev)
         begin
            if (id_seen == last_id)
            begin
               errors++;
               $display("eval_valid rose again for case %0d without a new board_valid edge",
                        id_seen);
            end
            else
            begin
               results++;
               compare_value("eval", 32'(eval), 32'(exp_eval));
               compare_value("material", material, exp_material);
               compare_value("insufficient_material", 32'(insufficient_material),
                             32'(exp_insufficient));
            end
            last_id       = id_seen;
            eval_held     = eval;
            material_held = material;
            insuf_held    = insufficient_material;
         end
         else if (eval_valid)
         begin
            if (eval !== eval_held || material !== material_held ||
                insufficient_material !== insuf_held)
            begin
               errors++;
               $display("Outputs of case %0d changed while eval_valid was held", id_seen);
            end
         end
         else if (valid_prev && clear_seen !== 1'b1)
         begin
            errors++;
            $display("eval_valid fell without clear_eval in case %0d", id_seen);
         end
         if (clear_seen === 1'b1 && eval_valid) // One edge after clear_eval
         begin
            errors++;
            $display("eval_valid stayed high after clear_eval in case %0d", id_seen);
         end
         valid_prev = eval_valid;
      end
   end

endmodule

// File: dv/tb_evaluate.sv
`timescale 1ns/1ps
`include "eval_consts.svh"

module tb_evaluate;
   import board_pkg::*;

   typedef struct packed
   {
      board_t                        board;
      logic signed [`EVAL_WIDTH-1:0] eval;
      logic signed [31:0]            material;
      logic                          insufficient;
      logic                          hold_valid;   // board_valid kept high across clear
   } case_t;

   logic                          clk;
   logic                          reset;
   logic                          board_valid;
   logic                          clear_eval;
   board_t                        board_in;
   logic signed [`EVAL_WIDTH-1:0] eval;
   logic                          eval_valid;
   logic signed [31:0]            material;
   logic                          insufficient_material;
   int                            case_id;
   logic signed [`EVAL_WIDTH-1:0] exp_eval;
   logic signed [31:0]            exp_material;
   logic                          exp_insufficient;
   int                            checker_errors;
   int                            results;
   int                            tb_errors = 0;
   int                            cycles = 0;
   int                            cycle_limit = 0;
   case_t                         cases [$];

   evaluate DUT (
      .clk(clk), .reset(reset), .board_valid(board_valid), .board_in(board_in),
      .clear_eval(clear_eval), .eval(eval), .eval_valid(eval_valid), .material(material),
      .insufficient_material(insufficient_material));

   eval_checker u_checker (
      .clk(clk), .reset(reset), .clear_eval(clear_eval), .eval_valid(eval_valid),
      .eval(eval), .material(material), .insufficient_material(insufficient_material),
      .case_id(case_id), .exp_eval(exp_eval), .exp_material(exp_material),
      .exp_insufficient(exp_insufficient), .errors(checker_errors), .results(results));

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycle_limit > 0 && cycles >= cycle_limit)
      begin
         $display("Timeout after %0d cycles, eval_valid never arrived for case %0d",
                  cycles, case_id);
         $display("Done: errors found");
         $finish;
      end
   end

   // Rows from rank 8 down to rank 1, upper case white, '.' empty
   function automatic board_t parse_board(input string rows);
      board_t b;
      piece_t p;
      byte    c;
      b = '0;
      for (int i = 0; i < 64; i++)
      begin
         c = rows[i];
         p = '0;
         p.black = (c >= "a" && c <= "z");
         case (c | 8'h20)
            "p":     p.kind = PAWN;
            "n":     p.kind = KNIGHT;
            "b":     p.kind = BISHOP;
            "r":     p.kind = ROOK;
            "q":     p.kind = QUEEN;
            "k":     p.kind = KING;
            default: p = '0;
         endcase
         b[(7 - i / 8) * 8 + i % 8] = p;
      end
      return b;
   endfunction

   task automatic add_case(input string rows, input int ev, input int mat,
                           input bit insuf, input bit hold);
      case_t c;
      c.board        = parse_board(rows);
      c.eval         = `EVAL_WIDTH'(ev);
      c.material     = mat;
      c.insufficient = insuf;
      c.hold_valid   = hold;
      cases.push_back(c);
   endtask

   task automatic load_cases();
      add_case({"rnbqkbnr", "pppppppp", "........", "........",       // Start position
                "........", "........", "PPPPPPPP", "RNBQKBNR"}, 0, 0, 0, 0);
      add_case({"rnb.kbnr", "pppppppp", "........", "........",       // Phase 31, 60791
                "........", "........", "PPPPPPPP", "RNBQKBNR"}, 980, 1025, 0, 0);
      add_case({"....k...", "........", "........", "........",       // Phase 3, 58299
                "........", "........", "........", "...QK..."}, 940, 1025, 0, 1);
      add_case({"r...k...", "........", "........", "........",       // Product -31639
                "........", "........", "........", "....K..."}, -510, -477, 0, 0);
      add_case({"....k...", ".....p..", "......p.", ".......p",       // mg 139, eg 123
                "...P....", "P.......", "P.....PP", "....K..."}, 125, 164, 0, 0);
      add_case({"....kb..", "........", "........", "........",       // Bishops only
                "........", "........", "........", "..B.K..."}, 0, 0, 1, 0);
      add_case({"....kb..", "........", "........", "........",       // Isolated a-pawn
                "........", "........", "P.......", "..B.K..."}, 78, 82, 0, 0);
   endtask

   task automatic run_case(input int idx);
      int gap;
      int hold;
      gap  = $urandom_range(6, 2);
      hold = $urandom_range(4, 1);
      repeat (gap) @(negedge clk);
      board_in         = cases[idx].board;
      case_id          = idx;
      exp_eval         = cases[idx].eval;
      exp_material     = cases[idx].material;
      exp_insufficient = cases[idx].insufficient;
      board_valid      = 1'b1;
      repeat (hold) @(negedge clk);
      if (!cases[idx].hold_valid)
         board_valid = 1'b0;
      while (!eval_valid)
         @(negedge clk);
      repeat (3) @(negedge clk);                // Result held without clear
      clear_eval = 1'b1;
      @(negedge clk);
      clear_eval = 1'b0;
      if (cases[idx].hold_valid)
      begin
         repeat (10) @(negedge clk);            // No second evaluation expected
         board_valid = 1'b0;
      end
   endtask

   initial
   begin
      void'($urandom(1));
      reset            = 1'b1;
      board_valid      = 1'b0;
      clear_eval       = 1'b0;
      board_in         = '0;
      case_id          = -1;
      exp_eval         = '0;
      exp_material     = '0;
      exp_insufficient = 1'b0;
      load_cases();
      cycle_limit = cases.size() * 60 + 100;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      foreach (cases[i])
         run_case(i);
      repeat (5) @(negedge clk);
      if (results != cases.size())
      begin
         tb_errors++;
         $display("Only %0d of %0d boards produced a checked result", results, cases.size());
      end
      $display("Results checked: %0d, errors: %0d", results, checker_errors + tb_errors);
      if (checker_errors + tb_errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

// File: sim.f
+incdir+hdl
hdl/board_pkg.sv
hdl/eval_pkg.sv
hdl/eval_material.sv
hdl/eval_pawns.sv
hdl/square_popcount.sv
hdl/evaluate.sv
dv/eval_checker.sv
dv/tb_evaluate.sv

// File: Makefile
# Verilator build and run for the position evaluator testbench

VERILATOR ?= verilator
TOP       ?= tb_evaluate
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

SOURCES := $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
